// File: fp16_dot.f
+incdir+include
logic/fp16_dot_pkg.sv
logic/lane_multiplier.sv
logic/exponent_compare.sv
logic/align_accumulate.sv
logic/normalize_round.sv
logic/fp16_dot.sv
verification/fp16_dot_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fp16_dot_tb \
    -f fp16_dot.f -o fp16_dot_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/fp16_dot_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

// File: verification/fp16_dot_tests.txt
# name with a0..a9 on its line, then b0..b9 and the expected result on the next
# All values are FP16 bit patterns in hex
one_times_one   3C00 0000 0000 0000 0000 0000 0000 0000 0000 0000
    3C00 0000 0000 0000 0000 0000 0000 0000 0000 0000   3C00
single_lane_mul 0000 0000 0000 3E00 0000 0000 0000 0000 0000 0000
    0000 0000 0000 4200 0000 0000 0000 0000 0000 0000   4480
round_carry     0000 3C01 0000 0000 0000 0000 0000 0000 0000 0000
    0000 3FFE 0000 0000 0000 0000 0000 0000 0000 0000   4000
neg_single      0000 0000 0000 0000 0000 0000 0000 0000 0000 BC00
    0000 0000 0000 0000 0000 0000 0000 0000 0000 3E00   BE00
cancel_to_zero  3C00 BC00 C000 3C00 0000 0000 0000 0000 0000 0000
    4000 4000 3800 3C00 0000 0000 0000 0000 0000 0000   0000
mixed_exponents 4000 3800 BC00 0000 0000 0000 0000 0000 0000 0000
    4000 3800 3C00 0000 0000 0000 0000 0000 0000 0000   4280
round_half_up   3C00 1400 0000 0000 0000 0000 0000 0000 0000 0000
    3C00 3800 0000 0000 0000 0000 0000 0000 0000 0000   3C01
shift_out       5800 8400 0000 0000 0000 0000 0000 0000 0000 0000
    5800 0400 0000 0000 0000 0000 0000 0000 0000 0000   7400
zero_lanes      7800 3C00 0000 8000 0000 0000 0000 0000 0000 0000
    0000 3C00 7BFF 7000 0000 0000 0000 0000 0000 0000   3C00
sum_of_ten      3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00
    3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00   4900
negative_sum    BE00 3800 0000 0000 0000 0000 0000 0000 0000 0000
    4000 3C00 0000 0000 0000 0000 0000 0000 0000 0000   C100
near_cancel     3C01 BC00 0000 0000 0000 0000 0000 0000 0000 0000
    3C00 3C00 0000 0000 0000 0000 0000 0000 0000 0000   1400

// File: verification/fp16_dot_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fp16_dot_settings.svh"

module fp16_dot_tb;

    import fp16_dot_pkg::*;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_SETS  = 24;
    localparam int WAIT_LIMIT   = 20;
    // Four cycles from the drive edge to out_valid, seen on the next negedge
    localparam time OUT_DELAY = (2 * `FP_LATENCY + 1) * HALF_PERIOD;

    logic  clk = 1'b0;
    logic  rst;
    logic  in_valid;
    fp16_t a [`FP_LANES];
    fp16_t b [`FP_LANES];
    fp16_t result;
    logic  out_valid;

    logic [8*24-1:0]         names [$];
    logic [16*`FP_LANES-1:0] a_sets [$];
    logic [16*`FP_LANES-1:0] b_sets [$];
    logic [15:0]             expected [$];
    time                     sent_at [$];
    logic [31:0]             lfsr;
    int                      errors;
    bit                      timed_out;

    fp16_dot DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .result    (result),
        .out_valid (out_valid)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    // Reference dot product from the lane arithmetic rule
    function automatic logic [15:0] dot_model(input logic [16*`FP_LANES-1:0] av,
                                             input logic [16*`FP_LANES-1:0] bv);
        logic [15:0] x;
        logic [15:0] y;
        logic [5:0]  exp_sum [`FP_LANES];
        longint      sig [`FP_LANES];
        logic        sgn [`FP_LANES];
        logic [5:0]  top;
        longint      acc;
        longint      mag;
        longint      term;
        int          p;
        int          e;
        int          man;
        top = '0;
        acc = 0;
        for (int i = 0; i < `FP_LANES; i++)
        begin
            x      = av[16*i +: 16];
            y      = bv[16*i +: 16];
            sgn[i] = x[15] ^ y[15];
            if (x[14:0] == '0 || y[14:0] == '0)
            begin
                exp_sum[i] = '0;
                sig[i]     = 0;
            end
            else
            begin
                exp_sum[i] = {1'b0, x[14:10]} + {1'b0, y[14:10]};
                sig[i]     = longint'({1'b1, x[9:0]}) * longint'({1'b1, y[9:0]});
            end
            if (exp_sum[i] > top)
                top = exp_sum[i];
        end
        for (int i = 0; i < `FP_LANES; i++)
        begin
            if (top - exp_sum[i] >= `FP_ALIGN_W)
                term = 0;
            else
                term = (sig[i] << `FP_GUARD_W) >> (top - exp_sum[i]);
            acc = sgn[i] ? acc - term : acc + term;
        end
        if (acc == 0)
            return 16'h0000;
        mag = (acc < 0) ? -acc : acc;
        p   = 0;
        for (int i = 0; i < 63; i++)
        begin
            if (mag[i])
                p = i;
        end
        e = int'(top) - `FP_BIAS + p - (`FP_ALIGN_W - 2);
        if (p >= `FP_MAN_W)
            man = int'((mag >> (p - `FP_MAN_W)) & 'h3ff);
        else
            man = int'((mag << (`FP_MAN_W - p)) & 'h3ff);
        if (p > `FP_MAN_W)
            man = man + int'((mag >> (p - `FP_MAN_W - 1)) & 1);
        if (man > 'h3ff)
        begin
            man = 0;
            e   = e + 1;
        end
        return {acc < 0, e[4:0], man[9:0]};
    endfunction

    task automatic load_tests();
        int                      fd;
        int                      n;
        logic [8*24-1:0]         tok;
        logic [8*128-1:0]        rest;
        logic [15:0]             op;
        logic [16*`FP_LANES-1:0] av;
        logic [16*`FP_LANES-1:0] bv;
        fd = $fopen("verification/fp16_dot_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verification/fp16_dot_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            tok = '0;
            n   = $fscanf(fd, "%s", tok);
            if (n != 1)
                break;
            if (tok == "#")
            begin
                n = $fgets(rest, fd);
                continue;
            end
            for (int i = 0; i <= 2 * `FP_LANES; i++)
            begin
                n = $fscanf(fd, "%h", op);
                if (n != 1)
                begin
                    $display("Test file entry %0s is missing values", tok);
                    errors++;
                end
                if (i < `FP_LANES)
                    av[16*i +: 16] = op;
                else if (i < 2 * `FP_LANES)
                    bv[16*(i-`FP_LANES) +: 16] = op;
            end
            names.push_back(tok);
            a_sets.push_back(av);
            b_sets.push_back(bv);
            expected.push_back(op);
        end
        $fclose(fd);
    endtask

    task automatic add_random_tests();
        logic [31:0]             s;
        logic [31:0]             e;
        logic [31:0]             m;
        logic [15:0]             op;
        logic [16*`FP_LANES-1:0] av;
        logic [16*`FP_LANES-1:0] bv;
        logic [8*24-1:0]         tag;
        for (int r = 0; r < RANDOM_SETS; r++)
        begin
            for (int i = 0; i < 2 * `FP_LANES; i++)
            begin
                take_bits(1, s);
                take_bits(4, e);
                take_bits(`FP_MAN_W, m);
                // Exponents 10 to 18
                op = {s[0], 5'(10 + e % 9), m[9:0]};
                if (i < `FP_LANES)
                    av[16*i +: 16] = op;
                else
                    bv[16*(i-`FP_LANES) +: 16] = op;
            end
            $sformat(tag, "random_%0d", r);
            names.push_back(tag);
            a_sets.push_back(av);
            b_sets.push_back(bv);
            expected.push_back(dot_model(av, bv));
        end
    endtask

    task automatic collect_results();
        int          waited;
        logic [15:0] got;
        for (int k = 0; k < names.size() && !timed_out; k++)
        begin
            waited = 0;
            @(negedge clk);
            while (!out_valid && waited < WAIT_LIMIT)
            begin
                if (k == 0)
                    assert (result == '0)
                    else
                    begin
                        $display("Result is not zero before the first output");
                        errors++;
                    end
                @(negedge clk);
                waited++;
            end
            got = result;
            if (!out_valid)
            begin
                $display("No out_valid for test %0s within %0d cycles", names[k], WAIT_LIMIT);
                errors++;
                timed_out = 1'b1;
            end
            else
            begin
                assert ($time - sent_at[k] == OUT_DELAY)
                else
                begin
                    $display("Test %0s came out %0t ns after it was driven, not %0t ns",
                             names[k], $time - sent_at[k], OUT_DELAY);
                    errors++;
                end
                assert (got === expected[k])
                    $display("passed %0s result %h", names[k], got);
                else
                begin
                    $display("** Error %0s: expected %h, actual %h", names[k], expected[k], got);
                    errors++;
                end
            end
        end
    endtask

    initial
    begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        for (int i = 0; i < `FP_LANES; i++)
        begin
            a[i] = '0;
            b[i] = '0;
        end
        lfsr      = 32'h0318dac3;
        errors    = 0;
        timed_out = 1'b0;
        load_tests();
        add_random_tests();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        fork
            begin
                // A few idle cycles before the first set
                repeat (3) @(posedge clk);
                for (int k = 0; k < names.size(); k++)
                begin
                    @(posedge clk);
                    in_valid <= 1'b1;
                    for (int i = 0; i < `FP_LANES; i++)
                    begin
                        a[i] <= a_sets[k][16*i +: 16];
                        b[i] <= b_sets[k][16*i +: 16];
                    end
                    sent_at.push_back($time);
                end
                @(posedge clk);
                in_valid <= 1'b0;
            end
            collect_results();
        join
        $display("%0d tests, %0d errors", names.size(), errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/fp16_dot.sv
`timescale 1ns/1ns
`default_nettype none

`include "fp16_dot_settings.svh"

module fp16_dot (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  fp16_dot_pkg::fp16_t a [`FP_LANES],
    input  fp16_dot_pkg::fp16_t b [`FP_LANES],
    output fp16_dot_pkg::fp16_t result,
    output logic                out_valid
);

    import fp16_dot_pkg::*;

    fp16_t               a_q [`FP_LANES];
    fp16_t               b_q [`FP_LANES];
    logic                vld_0;

    lane_product_t       prod_c [`FP_LANES];
    lane_shift_t         shift_c [`FP_LANES];
    logic [`FP_EXP_W:0]  max_exp_c;
    lane_product_t       prod_q [`FP_LANES];
    lane_shift_t         shift_q [`FP_LANES];
    logic [`FP_EXP_W:0]  max_exp_1;
    logic                vld_1;

    acc_t                sum_c;
    acc_t                sum_q;
    logic [`FP_EXP_W:0]  max_exp_2;
    logic                vld_2;

    fp16_t               result_c;

    // Valid bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            vld_0     <= 1'b0;
            vld_1     <= 1'b0;
            vld_2     <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            vld_0     <= in_valid;
            vld_1     <= vld_0;
            vld_2     <= vld_1;
            out_valid <= vld_2;
        end
    end

    // Data registers hold while their stage is idle
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            a_q <= a;
            b_q <= b;
        end
        if (vld_0)
        begin
            prod_q    <= prod_c;
            shift_q   <= shift_c;
            max_exp_1 <= max_exp_c;
        end
        if (vld_1)
        begin
            sum_q     <= sum_c;
            max_exp_2 <= max_exp_1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            result <= '0;
        else if (vld_2)
            result <= result_c;
    end

    for (genvar i = 0; i < `FP_LANES; i++)
    begin : g_lane
        lane_multiplier u_mul (
            .a_op    (a_q[i]),
            .b_op    (b_q[i]),
            .product (prod_c[i])
        );
    end

    exponent_compare u_cmp (
        .products (prod_c),
        .max_exp  (max_exp_c),
        .shifts   (shift_c)
    );

    align_accumulate u_acc (
        .products (prod_q),
        .shifts   (shift_q),
        .sum      (sum_c)
    );

    normalize_round u_norm (
        .sum     (sum_q),
        .max_exp (max_exp_2),
        .result  (result_c)
    );

    // One result per accepted set, four cycles later
    assert property (@(posedge clk) disable iff (rst)
        ##`FP_LATENCY (out_valid == $past(in_valid, `FP_LATENCY)))
        else $error("out_valid out of step with in_valid");

endmodule

`default_nettype wire

// File: logic/normalize_round.sv
`timescale 1ns/1ns
`default_nettype none

`include "fp16_dot_settings.svh"

module normalize_round (
    input  fp16_dot_pkg::acc_t  sum,
    input  logic [`FP_EXP_W:0]  max_exp,
    output fp16_dot_pkg::fp16_t result
);

    import fp16_dot_pkg::*;

    // Bit 30 of the sum carries the unit of max_exp, still double biased
    localparam int POINT_POS  = `FP_ALIGN_W - 2;
    localparam int EXP_OFFSET = `FP_BIAS + POINT_POS;

    logic                neg;
    logic [`FP_ACC_W-1:0] mag;
    logic [5:0]           lead;
    logic [`FP_ACC_W-1:0] norm;
    logic [`FP_MAN_W-1:0] man_rnd;
    logic                 round_carry;

    assign neg = sum[`FP_ACC_W-1];
    assign mag = neg ? -sum : sum;

    // Priority encoder, highest set bit wins
    always_comb
    begin
        lead = '0;
        for (int i = 0; i < `FP_ACC_W; i++)
        begin
            if (mag[i])
                lead = 6'(i);
        end
    end

    // Leading one moved to the top bit
    assign norm = mag << (`FP_ACC_W - 1 - lead);

    // Half-up on the first dropped bit
    assign {round_carry, man_rnd} =
        {1'b0, norm[`FP_ACC_W-2 -: `FP_MAN_W]} + norm[`FP_ACC_W-2-`FP_MAN_W];

    always_comb
    begin
        if (mag == '0)
        begin
            result = '0;
        end
        else
        begin
            result.sign = neg;
            result.exp  = `FP_EXP_W'(max_exp + lead + round_carry - EXP_OFFSET);
            // A carry out leaves the mantissa at zero
            result.man  = man_rnd;
        end
    end

    always_comb
    begin
        if (mag != '0)
            assert final (norm[`FP_ACC_W-1])
                else $error("normalized word lost its leading one");
    end

endmodule

`default_nettype wire

// File: logic/align_accumulate.sv
`timescale 1ns/1ns
`default_nettype none

`include "fp16_dot_settings.svh"

module align_accumulate (
    input  fp16_dot_pkg::lane_product_t products [`FP_LANES],
    input  fp16_dot_pkg::lane_shift_t   shifts [`FP_LANES],
    output fp16_dot_pkg::acc_t          sum
);

    import fp16_dot_pkg::*;

    logic [`FP_ALIGN_W-1:0] aligned [`FP_LANES];
    acc_t                   terms [`FP_LANES];
    acc_t                   lvl1 [5];
    acc_t                   lvl2 [3];
    acc_t                   lvl3 [2];

    // Guard bits catch part of what the shift would drop
    always_comb
    begin
        for (int i = 0; i < `FP_LANES; i++)
        begin
            aligned[i] = {products[i].sig, {`FP_GUARD_W{1'b0}}} >> shifts[i];
        end
    end

    always_comb
    begin
        acc_t mag;
        for (int i = 0; i < `FP_LANES; i++)
        begin
            mag      = acc_t'({{(`FP_ACC_W - `FP_ALIGN_W){1'b0}}, aligned[i]});
            terms[i] = products[i].sign ? -mag : mag;
        end
    end

    // Ten terms, four adder levels
    always_comb
    begin
        for (int i = 0; i < 5; i++)
        begin
            lvl1[i] = terms[2*i] + terms[2*i+1];
        end
        lvl2[0] = lvl1[0] + lvl1[1];
        lvl2[1] = lvl1[2] + lvl1[3];
        lvl2[2] = lvl1[4];
        lvl3[0] = lvl2[0] + lvl2[1];
        lvl3[1] = lvl2[2];
        sum     = lvl3[0] + lvl3[1];
    end

endmodule

`default_nettype wire

// File: logic/exponent_compare.sv
`timescale 1ns/1ns
`default_nettype none

`include "fp16_dot_settings.svh"

module exponent_compare (
    input  fp16_dot_pkg::lane_product_t products [`FP_LANES],
    output logic [`FP_EXP_W:0]          max_exp,
    output fp16_dot_pkg::lane_shift_t   shifts [`FP_LANES]
);

    import fp16_dot_pkg::*;

    localparam lane_shift_t SHIFT_MAX = lane_shift_t'(`FP_ALIGN_W);

    always_comb
    begin
        max_exp = '0;
        for (int i = 0; i < `FP_LANES; i++)
        begin
            if (products[i].exp_sum > max_exp)
                max_exp = products[i].exp_sum;
        end
    end

    always_comb
    begin
        lane_shift_t diff;
        for (int i = 0; i < `FP_LANES; i++)
        begin
            diff = max_exp - products[i].exp_sum;
            // Anything past the aligned width shifts out completely
            shifts[i] = (diff > SHIFT_MAX) ? SHIFT_MAX : diff;
        end
    end

    // An empty lane must not pull the maximum exponent up
    always_comb
    begin
        for (int i = 0; i < `FP_LANES; i++)
        begin
            assert final (products[i].sig != '0 || products[i].exp_sum == '0)
                else $error("lane %0d has an exponent sum but no significand", i);
        end
    end

endmodule

`default_nettype wire

// File: logic/lane_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

`include "fp16_dot_settings.svh"

module lane_multiplier (
    input  fp16_dot_pkg::fp16_t         a_op,
    input  fp16_dot_pkg::fp16_t         b_op,
    output fp16_dot_pkg::lane_product_t product
);

    logic                 a_zero;
    logic                 b_zero;
    logic [`FP_MAN_W:0]   a_sig;
    logic [`FP_MAN_W:0]   b_sig;

    // Only an all-zero exponent and mantissa counts as zero
    assign a_zero = (a_op.exp == '0) && (a_op.man == '0);
    assign b_zero = (b_op.exp == '0) && (b_op.man == '0);

    // Hidden bit restored
    assign a_sig = {1'b1, a_op.man};
    assign b_sig = {1'b1, b_op.man};

    always_comb
    begin
        product.sign = a_op.sign ^ b_op.sign;
        if (a_zero || b_zero)
        begin
            // Keeps a dead lane out of the maximum exponent
            product.exp_sum = '0;
            product.sig     = '0;
        end
        else
        begin
            product.exp_sum = {1'b0, a_op.exp} + {1'b0, b_op.exp};
            product.sig     = a_sig * b_sig;
        end
    end

endmodule

`default_nettype wire

// File: logic/fp16_dot_pkg.sv
`default_nettype none

`include "fp16_dot_settings.svh"

package fp16_dot_pkg;

    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] man;
    } fp16_t;

    // Exponent sum stays biased twice
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W:0]    exp_sum;
        logic [`FP_PROD_W-1:0] sig;
    } lane_product_t;

    // Right shift distance, saturated at the aligned width
    typedef logic [`FP_EXP_W:0] lane_shift_t;

    typedef logic signed [`FP_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// File: include/fp16_dot_settings.svh
`ifndef FP16_DOT_SETTINGS_SVH
`define FP16_DOT_SETTINGS_SVH

// Operand pairs per dot product
`define FP_LANES    10

// FP16 fields
`define FP_EXP_W    5
`define FP_MAN_W    10
`define FP_BIAS     15

// Datapath widths
`define FP_PROD_W   22
`define FP_GUARD_W  10
`define FP_ALIGN_W  (`FP_PROD_W + `FP_GUARD_W)
`define FP_ACC_W    (`FP_ALIGN_W + 4 + 1)

// Input register to result register
`define FP_LATENCY  4

`endif
